// File: include/mbz_params.svh
// Widths, NXM timeout and diagnostic codes for the memory box status slice, included by its RTL
`ifndef MBZ_PARAMS_SVH
`define MBZ_PARAMS_SVH

// Physical address bits carried by a reference
`define MBZ_PA_WIDTH 22

// Busy cycles without an acknowledge before the NXM chain starts
`define MBZ_NXM_TIMEOUT 16

// Diagnostic load function codes
`define MBZ_DIAG_FUNC_WIDTH 7
`define MBZ_DIAG_CLR_ERR 7'o070
`define MBZ_DIAG_EN_CSH 7'o071

// Diagnostic readback selects, code 3 reads as zero
`define MBZ_SEL_STATUS 2'd0
`define MBZ_SEL_ERA 2'd1
`define MBZ_SEL_REF 2'd2

`endif

// File: src/mbzPkg.sv
// Shared types of the memory box status slice, referenced by scoped name from every block
`default_nettype none
`include "mbz_params.svh"

package mbzPkg;

  typedef logic [`MBZ_PA_WIDTH-1:0] physAddr;

  // Diagnostic bus word, numbered from the left as on the EBUS
  typedef logic [0:35] ebusWord;

  typedef logic [1:0] diagSel;

  typedef logic [`MBZ_DIAG_FUNC_WIDTH-1:0] diagCode;

  // Counts busy cycles while waiting for an acknowledge
  typedef logic [$clog2(`MBZ_NXM_TIMEOUT)-1:0] nxmCount;

  typedef struct packed {
    physAddr addr;
    logic    write;
    logic    chanRef;
    logic    ccaRef;
  } memRef;

  typedef struct packed {
    logic nxmErr;
    logic parErr;
    logic sbusErr;
    logic adrParErr;
  } errFlags;

  typedef enum logic [2:0] {
    idle,
    waiting,
    t2,
    t3,
    t4,
    t5,
    t6
  } nxmState;

endpackage

`default_nettype wire

// File: src/nxmTimer.sv
// Tracks the outstanding memory reference and runs the NXM timing chain when no ack arrives
`timescale 1ns/1ps
`default_nettype none
`include "mbz_params.svh"

module nxmTimer (
  input  wire logic       MBOX,
  input  wire logic       rstN,
  input  wire logic       memStart,
  input  wire logic       ackn,
  input  wire logic       isRead,
  output logic            busy,
  output logic            nxmDone,
  output logic            nxmDataVal,
  output mbzPkg::nxmState state
);

  localparam mbzPkg::nxmCount LastCount = mbzPkg::nxmCount'(`MBZ_NXM_TIMEOUT - 1);

  mbzPkg::nxmState stateNext;
  mbzPkg::nxmCount waitCount;
  logic            readHeld;

  always_comb begin
    stateNext = state;
    unique case (state)
      mbzPkg::idle: begin
        if (memStart) begin
          stateNext = mbzPkg::waiting;
        end
      end
      mbzPkg::waiting: begin
        if (ackn) begin
          stateNext = mbzPkg::idle;
        end else if (waitCount == LastCount) begin
          stateNext = mbzPkg::t2;
        end
      end
      // Once the chain has started a late ack no longer matters
      mbzPkg::t2: stateNext = mbzPkg::t3;
      mbzPkg::t3: stateNext = mbzPkg::t4;
      mbzPkg::t4: stateNext = mbzPkg::t5;
      mbzPkg::t5: stateNext = mbzPkg::t6;
      mbzPkg::t6: stateNext = mbzPkg::idle;
      default:    stateNext = mbzPkg::idle;
    endcase
  end

  always_ff @(posedge MBOX) begin
    if (!rstN) begin
      state     <= mbzPkg::idle;
      waitCount <= '0;
    end else begin
      state <= stateNext;
      // First waiting cycle sees zero
      if (state == mbzPkg::waiting) begin
        waitCount <= waitCount + 1'b1;
      end else begin
        waitCount <= '0;
      end
    end
  end

  // Direction of the reference that may time out
  always_ff @(posedge MBOX) begin
    if (memStart) begin
      readHeld <= isRead;
    end
  end

  assign busy    = (state != mbzPkg::idle);
  assign nxmDone = (state == mbzPkg::t6);

  // Synthesized read data is handed back at t6
  assign nxmDataVal = nxmDone & readHeld;

endmodule

`default_nettype wire

// File: src/errorCapture.sv
// Sticky memory error flags and the error address register that freezes on the first error
`timescale 1ns/1ps
`default_nettype none

module errorCapture (
  input  wire logic          MBOX,
  input  wire logic          rstN,
  input  wire logic          memStart,
  input  wire mbzPkg::memRef startRef,
  input  wire logic          ackn,
  input  wire logic          readParOk,
  input  wire logic          sbusErrIn,
  input  wire logic          adrParErrIn,
  input  wire logic          busy,
  input  wire logic          nxmDone,
  input  wire logic          clrErr,
  output mbzPkg::errFlags    flags,
  output logic               holdEra,
  output mbzPkg::memRef      era,
  output logic               chanErr
);

  mbzPkg::errFlags flagSet;
  logic            writeHeld;

  // Direction of the current reference, tracked even while the ERA is held
  always_ff @(posedge MBOX) begin
    if (memStart) begin
      writeHeld <= startRef.write;
    end
  end

  always_comb begin
    flagSet.nxmErr    = nxmDone;
    flagSet.parErr    = ackn & ~writeHeld & ~readParOk;
    // Bus and address parity errors only count against a live reference
    flagSet.sbusErr   = sbusErrIn & busy;
    flagSet.adrParErr = adrParErrIn & busy;
  end

  always_ff @(posedge MBOX) begin
    if (!rstN) begin
      flags <= '0;
    end else if (clrErr) begin
      flags <= flagSet;
    end else begin
      flags <= flags | flagSet;
    end
  end

  assign holdEra = |flags;

  // Failing reference stays put until diagnostics clear the flags
  always_ff @(posedge MBOX) begin
    if (!rstN) begin
      era <= '0;
    end else if (memStart && !holdEra) begin
      era <= startRef;
    end
  end

  assign chanErr = holdEra & era.chanRef;

endmodule

`default_nettype wire

// File: src/diagRegs.sv
// Diagnostic function decode and EBUS readback of status, ERA address and reference bits
`timescale 1ns/1ps
`default_nettype none
`include "mbz_params.svh"

module diagRegs (
  input  wire logic            MBOX,
  input  wire logic            rstN,
  input  wire logic            diagLoad,
  input  wire mbzPkg::diagCode diagFunc,
  input  wire logic            diagRead,
  input  wire mbzPkg::diagSel  diagSelect,
  input  wire mbzPkg::errFlags flags,
  input  wire logic            holdEra,
  input  wire mbzPkg::memRef   era,
  input  wire logic            busy,
  output logic                 clrErr,
  output logic                 cshEnable,
  output mbzPkg::ebusWord      ebusData,
  output logic                 ebusDriving
);

  mbzPkg::ebusWord statusWord;
  mbzPkg::ebusWord eraWord;
  mbzPkg::ebusWord refWord;

  // Clear takes effect at the next edge
  assign clrErr = diagLoad && (diagFunc == `MBZ_DIAG_CLR_ERR);

  always_ff @(posedge MBOX) begin
    if (!rstN) begin
      cshEnable <= 1'b0;
    end else if (diagLoad && (diagFunc == `MBZ_DIAG_EN_CSH)) begin
      cshEnable <= 1'b1;
    end
  end

  // Status bits sit at the left end of the word
  assign statusWord = {busy, flags, holdEra, cshEnable, 29'b0};

  // Physical address right justified, as in bits 14..35
  assign eraWord = {{($bits(mbzPkg::ebusWord) - `MBZ_PA_WIDTH){1'b0}}, era.addr};

  assign refWord = {era.write, era.chanRef, era.ccaRef, 33'b0};

  always_comb begin
    ebusData = '0;
    if (diagRead) begin
      case (diagSelect)
        `MBZ_SEL_STATUS: ebusData = statusWord;
        `MBZ_SEL_ERA:    ebusData = eraWord;
        `MBZ_SEL_REF:    ebusData = refWord;
        default:         ebusData = '0;
      endcase
    end
  end

  assign ebusDriving = diagRead;

endmodule

`default_nettype wire

// File: src/mbzCore.sv
// Top of the memory box status slice, connecting NXM timing, error capture and diagnostics
`timescale 1ns/1ps
`default_nettype none

module mbzCore (
  input  wire logic            MBOX,
  input  wire logic            rstN,
  input  wire logic            memStart,
  input  wire mbzPkg::memRef   startRef,
  input  wire logic            ackn,
  input  wire logic            readParOk,
  input  wire logic            sbusErrIn,
  input  wire logic            adrParErrIn,
  input  wire logic            diagLoad,
  input  wire mbzPkg::diagCode diagFunc,
  input  wire logic            diagRead,
  input  wire mbzPkg::diagSel  diagSelect,
  output wire logic            coreBusy,
  output wire logic            nxmDataVal,
  output mbzPkg::errFlags      flags,
  output wire logic            chanErr,
  output mbzPkg::ebusWord      ebusData,
  output wire logic            ebusDriving
);

  wire logic      isRead;
  wire logic      nxmDone;
  wire logic      holdEra;
  wire logic      clrErr;
  mbzPkg::memRef  era;
  mbzPkg::nxmState state;

  assign isRead = ~startRef.write;

  nxmTimer nxmTimer (
    .MBOX       (MBOX),
    .rstN       (rstN),
    .memStart   (memStart),
    .ackn       (ackn),
    .isRead     (isRead),
    .busy       (coreBusy),
    .nxmDone    (nxmDone),
    .nxmDataVal (nxmDataVal),
    .state      (state)
  );

  errorCapture errorCapture (
    .MBOX        (MBOX),
    .rstN        (rstN),
    .memStart    (memStart),
    .startRef    (startRef),
    .ackn        (ackn),
    .readParOk   (readParOk),
    .sbusErrIn   (sbusErrIn),
    .adrParErrIn (adrParErrIn),
    .busy        (coreBusy),
    .nxmDone     (nxmDone),
    .clrErr      (clrErr),
    .flags       (flags),
    .holdEra     (holdEra),
    .era         (era),
    .chanErr     (chanErr)
  );

  // Cache-data enable is seen only through the status readback
  diagRegs diagRegs (
    .MBOX        (MBOX),
    .rstN        (rstN),
    .diagLoad    (diagLoad),
    .diagFunc    (diagFunc),
    .diagRead    (diagRead),
    .diagSelect  (diagSelect),
    .flags       (flags),
    .holdEra     (holdEra),
    .era         (era),
    .busy        (coreBusy),
    .clrErr      (clrErr),
    .cshEnable   (),
    .ebusData    (ebusData),
    .ebusDriving (ebusDriving)
  );

endmodule

`default_nettype wire

// File: testbench/mbzCore_chk.sv
// Concurrent assertions on busy, NXM and ERA behavior, bound into mbzCore by the testbench
`timescale 1ns/1ps
`default_nettype none

module mbzCore_chk (
  input wire logic            MBOX,
  input wire logic            rstN,
  input wire logic            memStart,
  input wire logic            ackn,
  input wire logic            coreBusy,
  input wire mbzPkg::nxmState state,
  input wire logic            holdEra,
  input wire mbzPkg::memRef   era
);

  int failCount = 0;

  // Only one reference may be outstanding
  noStartWhileBusy: assert property (@(posedge MBOX) disable iff (!rstN)
    memStart |-> !coreBusy)
    else begin
      failCount++;
      $error("memStart arrived while a reference was outstanding");
    end

  // Ack in the wait window or the end of the NXM chain frees the reference
  busyFallsAtEnd: assert property (@(posedge MBOX) disable iff (!rstN)
    ((state == mbzPkg::waiting && ackn) || state == mbzPkg::t6) |=> !coreBusy)
    else begin
      failCount++;
      $error("coreBusy stayed high after the reference ended");
    end

  eraHeld: assert property (@(posedge MBOX) disable iff (!rstN)
    holdEra |=> $stable(era))
    else begin
      failCount++;
      $error("ERA changed while an error was held");
    end

endmodule

`default_nettype wire

// File: testbench/mbzCore_tb.sv
// Self-checking testbench for mbzCore with seeded random references and a reference model
`timescale 1ns/1ps
`default_nettype none
`include "mbz_params.svh"

module mbzCore_tb;

  parameter int Seed = 92112;
  localparam int NumRefs = 40;
  // Worst case per reference covers the NXM chain and the readbacks after it
  localparam int RefCycles = `MBZ_NXM_TIMEOUT + 16;
  localparam int WatchdogNs = ((2 * NumRefs + 30) * RefCycles + 200) * 100;

  logic            MBOX;
  logic            rstN;
  logic            memStart;
  mbzPkg::memRef   startRef;
  logic            ackn;
  logic            readParOk;
  logic            sbusErrIn;
  logic            adrParErrIn;
  logic            diagLoad;
  mbzPkg::diagCode diagFunc;
  logic            diagRead;
  mbzPkg::diagSel  diagSelect;
  logic            coreBusy;
  logic            nxmDataVal;
  mbzPkg::errFlags flags;
  logic            chanErr;
  mbzPkg::ebusWord ebusData;
  logic            ebusDriving;

  // Model state
  mbzPkg::errFlags expFlags;
  mbzPkg::memRef   expEra;
  logic            expCsh;
  logic            expBusy;
  int              errors;
  int              markErrors;
  int              testCount;
  int              failedTests;

  mbzCore dut (.*);

  bind mbzCore mbzCore_chk chk (.*);

  always #50 MBOX = ~MBOX;

  task automatic reportError(input string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    errors++;
  endtask

  task automatic endTest(input string name);
    testCount++;
    if (errors == markErrors) begin
      $display("Test %0d %s: pass", testCount, name);
    end else begin
      failedTests++;
      $display("Test %0d %s: fail, %0d errors", testCount, name, errors - markErrors);
    end
    markErrors = errors;
  endtask

  task automatic nextCycle();
    @(negedge MBOX);
  endtask

  function automatic mbzPkg::memRef randomRef();
    mbzPkg::memRef r;
    r.addr = mbzPkg::physAddr'($urandom);
    r.write = 1'($urandom);
    r.chanRef = 1'($urandom);
    r.ccaRef = 1'($urandom);
    return r;
  endfunction

  // Busy bit comes from the model's view of an outstanding reference
  function automatic mbzPkg::ebusWord expectedWord(input mbzPkg::diagSel sel);
    mbzPkg::ebusWord w;
    w = '0;
    if (sel == `MBZ_SEL_STATUS) begin
      w[0] = expBusy;
      w[1:4] = expFlags;
      w[5] = |expFlags;
      w[6] = expCsh;
    end else if (sel == `MBZ_SEL_ERA) begin
      w[36-`MBZ_PA_WIDTH:35] = expEra.addr;
    end else if (sel == `MBZ_SEL_REF) begin
      w[0:2] = {expEra.write, expEra.chanRef, expEra.ccaRef};
    end
    return w;
  endfunction

  task automatic checkState(input string where);
    if (coreBusy !== 1'b0) reportError({"coreBusy still high ", where});
    if (flags !== expFlags) begin
      reportError($sformatf("flags %b expected %b %s", flags, expFlags, where));
    end
    if (chanErr !== ((|expFlags) & expEra.chanRef)) reportError({"chanErr wrong ", where});
  endtask

  task automatic issueStart(input mbzPkg::memRef r);
    nextCycle();
    memStart = 1'b1;
    startRef = r;
    // The ERA follows references only while no error is held
    if (expFlags == '0) expEra = r;
    nextCycle();
    memStart = 1'b0;
    if (coreBusy !== 1'b1) reportError("coreBusy did not rise one cycle after memStart");
  endtask

  task automatic runAcked(input mbzPkg::memRef r, input int ackDelay, input logic parOk,
                          input logic sbus, input logic adrPar);
    int i;
    issueStart(r);
    sbusErrIn = sbus;
    adrParErrIn = adrPar;
    for (i = 0; i < ackDelay; i++) begin
      if (coreBusy !== 1'b1) reportError("coreBusy fell before ackn");
      nextCycle();
      sbusErrIn = 1'b0;
      adrParErrIn = 1'b0;
    end
    ackn = 1'b1;
    readParOk = parOk;
    nextCycle();
    ackn = 1'b0;
    readParOk = 1'b1;
    sbusErrIn = 1'b0;
    adrParErrIn = 1'b0;
    expFlags.parErr |= !r.write && !parOk;
    expFlags.sbusErr |= sbus;
    expFlags.adrParErr |= adrPar;
    checkState("after ackn");
  endtask

  task automatic checkReadback(input mbzPkg::diagSel sel);
    mbzPkg::ebusWord want;
    want = expectedWord(sel);
    nextCycle();
    diagRead = 1'b1;
    diagSelect = sel;
    #10;
    if (ebusDriving !== 1'b1) reportError("ebusDriving low while diagRead is high");
    if (ebusData !== want) begin
      reportError($sformatf("readback sel %0d got %h expected %h", sel, ebusData, want));
    end
    nextCycle();
    diagRead = 1'b0;
    #10;
    if (ebusDriving !== 1'b0 || ebusData !== '0) reportError("EBUS driven after diagRead fell");
  endtask

  task automatic runNxm(input mbzPkg::memRef r);
    int busyCycles;
    int pulses;
    pulses = 0;
    issueStart(r);
    // Status read while the reference is still outstanding
    expBusy = 1'b1;
    checkReadback(`MBZ_SEL_STATUS);
    expBusy = 1'b0;
    // The status read used the first two busy cycles
    busyCycles = 2;
    while (coreBusy === 1'b1 && busyCycles < RefCycles) begin
      if (nxmDataVal === 1'b1) pulses++;
      busyCycles++;
      nextCycle();
    end
    expFlags.nxmErr = 1'b1;
    // Whole wait window, then t2 through t6
    if (busyCycles != `MBZ_NXM_TIMEOUT + 5) begin
      reportError($sformatf("coreBusy high for %0d cycles on NXM", busyCycles));
    end
    if (pulses != (r.write ? 0 : 1)) reportError($sformatf("nxmDataVal pulsed %0d times", pulses));
    checkState("after NXM");
  endtask

  task automatic diagStrobe(input mbzPkg::diagCode code);
    nextCycle();
    diagLoad = 1'b1;
    diagFunc = code;
    nextCycle();
    diagLoad = 1'b0;
    diagFunc = '0;
    if (code == `MBZ_DIAG_CLR_ERR) expFlags = '0;
    if (code == `MBZ_DIAG_EN_CSH) expCsh = 1'b1;
    if (flags !== expFlags) reportError("flags wrong after diagnostic load");
  endtask

  task automatic pulseIdle();
    nextCycle();
    sbusErrIn = 1'b1;
    adrParErrIn = 1'b1;
    nextCycle();
    sbusErrIn = 1'b0;
    adrParErrIn = 1'b0;
    if (flags !== expFlags) reportError("error pulse outside busy changed the flags");
  endtask

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, the tests did not finish", WatchdogNs);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    mbzPkg::memRef r;
    int n;
    int kind;
    MBOX = 1'b0;
    rstN = 1'b0;
    memStart = 1'b0;
    startRef = '0;
    ackn = 1'b0;
    readParOk = 1'b1;
    sbusErrIn = 1'b0;
    adrParErrIn = 1'b0;
    diagLoad = 1'b0;
    diagFunc = '0;
    diagRead = 1'b0;
    diagSelect = '0;
    expFlags = '0;
    expEra = '0;
    expCsh = 1'b0;
    expBusy = 1'b0;
    errors = 0;
    markErrors = 0;
    testCount = 0;
    failedTests = 0;
    void'($urandom(Seed));
    repeat (2) nextCycle();
    rstN = 1'b1;

    if (coreBusy !== 1'b0 || nxmDataVal !== 1'b0) reportError("busy or nxmDataVal after reset");
    if (flags !== '0 || ebusDriving !== 1'b0) reportError("flags or EBUS active after reset");
    checkReadback(`MBZ_SEL_STATUS);
    endTest("reset");

    for (n = 0; n < NumRefs; n++) begin
      runAcked(randomRef(), $urandom_range(`MBZ_NXM_TIMEOUT - 1, 0), 1'b1, 1'b0, 1'b0);
    end
    endTest("acknowledged references");

    r = randomRef();
    r.write = 1'b0;
    runNxm(r);
    r = randomRef();
    r.write = 1'b1;
    runNxm(r);
    runNxm(randomRef());
    checkReadback(`MBZ_SEL_ERA);
    checkReadback(`MBZ_SEL_REF);
    diagStrobe(`MBZ_DIAG_CLR_ERR);
    endTest("NXM timeout");

    r = randomRef();
    r.write = 1'b0;
    runAcked(r, 2, 1'b0, 1'b0, 1'b0);
    diagStrobe(`MBZ_DIAG_CLR_ERR);
    r.write = 1'b1;
    runAcked(r, 3, 1'b0, 1'b0, 1'b0);
    runAcked(randomRef(), 1, 1'b1, 1'b1, 1'b0);
    diagStrobe(`MBZ_DIAG_CLR_ERR);
    runAcked(randomRef(), 0, 1'b1, 1'b0, 1'b1);
    diagStrobe(`MBZ_DIAG_CLR_ERR);
    pulseIdle();
    endTest("parity and bus errors");

    for (n = 0; n < NumRefs; n++) begin
      kind = $urandom_range(7, 0);
      runAcked(randomRef(), $urandom_range(`MBZ_NXM_TIMEOUT - 1, 0), kind != 3, kind == 1,
               kind == 2);
      checkReadback(`MBZ_SEL_ERA);
      checkReadback(`MBZ_SEL_REF);
      if ($urandom_range(5, 0) == 0) diagStrobe(`MBZ_DIAG_CLR_ERR);
    end
    endTest("ERA hold");

    runAcked(randomRef(), 1, 1'b1, 1'b1, 1'b1);
    checkReadback(`MBZ_SEL_STATUS);
    diagStrobe(`MBZ_DIAG_EN_CSH);
    checkReadback(`MBZ_SEL_STATUS);
    checkReadback(2'd3);
    diagStrobe(`MBZ_DIAG_CLR_ERR);
    checkReadback(`MBZ_SEL_STATUS);
    // Released ERA picks up the next reference
    runAcked(randomRef(), 4, 1'b1, 1'b0, 1'b0);
    checkReadback(`MBZ_SEL_ERA);
    checkReadback(`MBZ_SEL_REF);
    endTest("diagnostic clear and readback");

    if (dut.chk.failCount != 0) begin
      $display("Bound checker saw %0d assertion failures", dut.chk.failCount);
      errors += dut.chk.failCount;
    end
    $display("%0d tests, %0d failed, %0d check errors", testCount, failedTests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mbzCore.f
+incdir+include
src/mbzPkg.sv
src/nxmTimer.sv
src/errorCapture.sv
src/diagRegs.sv
src/mbzCore.sv
testbench/mbzCore_chk.sv
testbench/mbzCore_tb.sv

// File: Makefile
TOP       ?= mbzCore_tb
SEED      ?= 92112
VERILATOR ?= verilator
FILELIST  ?= mbzCore.f
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert -GSeed=$(SEED) -f $(FILELIST) \
	  --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)
